// File: hw/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // Line and address geometry.
    localparam int LINE_BITS      = 256;
    localparam int ADDR_BITS      = 32;
    localparam int OFFSET_BITS    = 5;
    localparam int SET_BITS       = 3;
    localparam int TAG_BITS       = 24;

    // The eviction buffer compares on the full line address (address bits 31 to 5).
    localparam int LINE_ADDR_BITS = 27;

    // Eviction write buffer geometry.
    // The depth must stay a power of two so that the pointers wrap on their own.
    localparam int EWB_INDEX      = 2;
    localparam int EWB_DEPTH      = 4;

    typedef logic [LINE_BITS-1:0]      line_t;
    typedef logic [ADDR_BITS-1:0]      addr_t;
    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;
    typedef logic [SET_BITS-1:0]       set_t;
    typedef logic [TAG_BITS-1:0]       tag_t;

    // Miss handling states of the line cache.
    typedef enum logic [2:0] {
        IDLE,
        EVICT,
        CHECK,
        FILL,
        RESPOND
    } cache_state_t;

endpackage : cache_pkg

`default_nettype wire

// File: hw/cache_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module cache_subsystem (
    input  wire logic             clk,
    input  wire logic             rst,

    input  wire logic             mem_read_i,
    input  wire logic             mem_write_i,
    input  wire cache_pkg::addr_t mem_addr_i,
    input  wire cache_pkg::line_t mem_wdata_i,
    output logic                  mem_resp_o,
    output cache_pkg::line_t      mem_rdata_o,

    input  wire logic             pmem_resp_i,
    input  wire cache_pkg::line_t pmem_rdata_i,
    output logic                  pmem_read_o,
    output logic                  pmem_write_o,
    output cache_pkg::addr_t      pmem_addr_o,
    output cache_pkg::line_t      pmem_wdata_o
);

    // Cache to buffer.
    logic                  ewb_push;
    logic                  ewb_full;
    cache_pkg::line_t      ewb_wdata;
    cache_pkg::addr_t      ewb_waddr;
    logic                  ewb_check;
    cache_pkg::line_addr_t ewb_tag;
    logic                  ewb_hit;
    cache_pkg::line_t      ewb_rdata;

    // Buffer to arbiter.
    logic                  ewb_empty;
    cache_pkg::line_t      ewb_head_data;
    cache_pkg::addr_t      ewb_head_addr;
    logic                  ewb_yumi;

    // Cache to arbiter.
    logic                  fill_read;
    cache_pkg::addr_t      fill_addr;
    logic                  fill_resp;
    cache_pkg::line_t      fill_rdata;

    line_cache u_cache (
        .clk          (clk),
        .rst          (rst),
        .mem_read_i   (mem_read_i),
        .mem_write_i  (mem_write_i),
        .mem_addr_i   (mem_addr_i),
        .mem_wdata_i  (mem_wdata_i),
        .mem_resp_o   (mem_resp_o),
        .mem_rdata_o  (mem_rdata_o),
        .ewb_full_i   (ewb_full),
        .ewb_hit_i    (ewb_hit),
        .ewb_rdata_i  (ewb_rdata),
        .ewb_push_o   (ewb_push),
        .ewb_wdata_o  (ewb_wdata),
        .ewb_waddr_o  (ewb_waddr),
        .ewb_check_o  (ewb_check),
        .ewb_tag_o    (ewb_tag),
        .fill_resp_i  (fill_resp),
        .fill_rdata_i (fill_rdata),
        .fill_read_o  (fill_read),
        .fill_addr_o  (fill_addr)
    );

    ewb u_ewb (
        .clk         (clk),
        .rst         (rst),
        .data_i      (ewb_wdata),
        .addr_i      (ewb_waddr),
        .valid_i     (ewb_push),
        .full_o      (ewb_full),
        .tag_check_i (ewb_check),
        .tag_i       (ewb_tag),
        .hit_o       (ewb_hit),
        .read_o      (ewb_rdata),
        .empty_o     (ewb_empty),
        .data_o      (ewb_head_data),
        .addr_o      (ewb_head_addr),
        .yumi_i      (ewb_yumi)
    );

    mem_arbiter u_arb (
        .clk          (clk),
        .rst          (rst),
        .fill_read_i  (fill_read),
        .fill_addr_i  (fill_addr),
        .fill_resp_o  (fill_resp),
        .fill_rdata_o (fill_rdata),
        .ewb_empty_i  (ewb_empty),
        .ewb_data_i   (ewb_head_data),
        .ewb_addr_i   (ewb_head_addr),
        .ewb_yumi_o   (ewb_yumi),
        .pmem_resp_i  (pmem_resp_i),
        .pmem_rdata_i (pmem_rdata_i),
        .pmem_read_o  (pmem_read_o),
        .pmem_write_o (pmem_write_o),
        .pmem_addr_o  (pmem_addr_o),
        .pmem_wdata_o (pmem_wdata_o)
    );

endmodule : cache_subsystem

`default_nettype wire

// File: hw/ewb.sv
`timescale 1ns/100ps
`default_nettype none

module ewb (
    input  wire logic                  clk,
    input  wire logic                  rst,

    // Victim push from the cache.
    input  wire cache_pkg::line_t      data_i,
    input  wire cache_pkg::addr_t      addr_i,
    input  wire logic                  valid_i,
    output logic                       full_o,

    // Tag search with its answer one cycle later.
    input  wire logic                  tag_check_i,
    input  wire cache_pkg::line_addr_t tag_i,
    output logic                       hit_o,
    output cache_pkg::line_t           read_o,

    // Drain of the oldest entry towards memory.
    output logic                       empty_o,
    output cache_pkg::line_t           data_o,
    output cache_pkg::addr_t           addr_o,
    input  wire logic                  yumi_i
);

    cache_pkg::line_t queue_data [cache_pkg::EWB_DEPTH];
    cache_pkg::addr_t queue_addr [cache_pkg::EWB_DEPTH];

    logic [cache_pkg::EWB_INDEX-1:0] read_ptr;
    logic [cache_pkg::EWB_INDEX-1:0] write_ptr;
    logic [cache_pkg::EWB_INDEX:0]   count;

    logic             enqueue;
    logic             dequeue;
    logic             match;
    cache_pkg::line_t match_line;

    assign full_o  = (count == cache_pkg::EWB_DEPTH);
    assign empty_o = (count == '0);
    assign enqueue = valid_i && !full_o;
    assign dequeue = yumi_i && !empty_o;

    // The head of the queue is always on display for the arbiter.
    assign data_o = queue_data[read_ptr];
    assign addr_o = queue_addr[read_ptr];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            read_ptr  <= '0;
            write_ptr <= '0;
            count     <= '0;
        end else begin
            if (enqueue) begin
                write_ptr <= write_ptr + 1'b1;
            end
            if (dequeue) begin
                read_ptr <= read_ptr + 1'b1;
            end
            // A push and a drain in the same cycle leave the occupancy unchanged.
            case ({enqueue, dequeue})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (enqueue) begin
            queue_data[write_ptr] <= data_i;
            queue_addr[write_ptr] <= addr_i;
        end
    end

    // Walk the occupied entries from oldest to youngest.
    // A later match overrides an earlier one, so the youngest copy of a line wins.
    always_comb begin
        logic [cache_pkg::EWB_INDEX-1:0] idx;

        match      = 1'b0;
        match_line = queue_data[read_ptr];
        idx        = read_ptr;
        for (int i = 0; i < cache_pkg::EWB_DEPTH; i++) begin
            if ((i < int'(count)) &&
                (queue_addr[idx][cache_pkg::ADDR_BITS-1:cache_pkg::OFFSET_BITS] == tag_i)) begin
                match      = 1'b1;
                match_line = queue_data[idx];
            end
            idx = idx + 1'b1;
        end
    end

    // The hit flag is rebuilt on every check and cleared when nothing matched.
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            hit_o <= 1'b0;
        end else if (tag_check_i) begin
            hit_o <= match;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_check_i && match) begin
            read_o <= match_line;
        end
    end

endmodule : ewb

`default_nettype wire

// File: hw/line_cache.sv
`timescale 1ns/100ps
`default_nettype none

module line_cache (
    input  wire logic                  clk,
    input  wire logic                  rst,

    // Upstream client.
    input  wire logic                  mem_read_i,
    input  wire logic                  mem_write_i,
    input  wire cache_pkg::addr_t      mem_addr_i,
    input  wire cache_pkg::line_t      mem_wdata_i,
    output logic                       mem_resp_o,
    output cache_pkg::line_t           mem_rdata_o,

    // Eviction write buffer.
    input  wire logic                  ewb_full_i,
    input  wire logic                  ewb_hit_i,
    input  wire cache_pkg::line_t      ewb_rdata_i,
    output logic                       ewb_push_o,
    output cache_pkg::line_t           ewb_wdata_o,
    output cache_pkg::addr_t           ewb_waddr_o,
    output logic                       ewb_check_o,
    output cache_pkg::line_addr_t      ewb_tag_o,

    // Line fills through the memory arbiter.
    input  wire logic                  fill_resp_i,
    input  wire cache_pkg::line_t      fill_rdata_i,
    output logic                       fill_read_o,
    output cache_pkg::addr_t           fill_addr_o
);

    // Per set state. Valid and dirty bits are kept as flat vectors.
    logic [2**cache_pkg::SET_BITS-1:0] valid_q;
    logic [2**cache_pkg::SET_BITS-1:0] dirty_q;
    cache_pkg::tag_t                   tag_q  [2**cache_pkg::SET_BITS];
    cache_pkg::line_t                  data_q [2**cache_pkg::SET_BITS];

    cache_pkg::cache_state_t state;
    cache_pkg::cache_state_t state_next;

    cache_pkg::line_addr_t req_line;
    cache_pkg::set_t       req_set;
    cache_pkg::tag_t       req_tag;
    logic                  req_valid;
    logic                  hit;

    // Line installation is shared by write hits, write misses, forwards and fills.
    logic             install;
    logic             install_dirty;
    cache_pkg::line_t install_line;

    // The client holds its request until the response, so the address is used directly.
    assign req_line  = mem_addr_i[cache_pkg::ADDR_BITS-1:cache_pkg::OFFSET_BITS];
    assign req_set   = req_line[cache_pkg::SET_BITS-1:0];
    assign req_tag   = req_line[cache_pkg::LINE_ADDR_BITS-1:cache_pkg::SET_BITS];
    assign req_valid = mem_read_i || mem_write_i;
    assign hit       = valid_q[req_set] && (tag_q[req_set] == req_tag);

    assign mem_rdata_o = data_q[req_set];

    // The victim address is rebuilt from the stored tag and the set index.
    assign ewb_wdata_o = data_q[req_set];
    assign ewb_waddr_o = {tag_q[req_set], req_set, {cache_pkg::OFFSET_BITS{1'b0}}};
    assign ewb_tag_o   = req_line;
    assign fill_addr_o = {req_line, {cache_pkg::OFFSET_BITS{1'b0}}};

    always_comb begin
        state_next    = state;
        mem_resp_o    = 1'b0;
        ewb_push_o    = 1'b0;
        ewb_check_o   = 1'b0;
        fill_read_o   = 1'b0;
        install       = 1'b0;
        install_dirty = 1'b0;
        install_line  = mem_wdata_i;

        case (state)
            cache_pkg::IDLE: begin
                if (req_valid) begin
                    if (hit) begin
                        install       = mem_write_i;
                        install_dirty = 1'b1;
                        state_next    = cache_pkg::RESPOND;
                    end else if (valid_q[req_set] && dirty_q[req_set]) begin
                        state_next = cache_pkg::EVICT;
                    end else if (mem_write_i) begin
                        // Writes cover the whole line, so no fill is needed.
                        install       = 1'b1;
                        install_dirty = 1'b1;
                        state_next    = cache_pkg::RESPOND;
                    end else begin
                        ewb_check_o = 1'b1;
                        state_next  = cache_pkg::CHECK;
                    end
                end
            end

            cache_pkg::EVICT: begin
                // Stay here while the buffer is full.
                if (!ewb_full_i) begin
                    ewb_push_o = 1'b1;
                    if (mem_write_i) begin
                        install       = 1'b1;
                        install_dirty = 1'b1;
                        state_next    = cache_pkg::RESPOND;
                    end else begin
                        // The victim never matches the miss line, so the check shares this cycle.
                        ewb_check_o = 1'b1;
                        state_next  = cache_pkg::CHECK;
                    end
                end
            end

            cache_pkg::CHECK: begin
                if (ewb_hit_i) begin
                    install      = 1'b1;
                    install_line = ewb_rdata_i;
                    state_next   = cache_pkg::RESPOND;
                end else begin
                    state_next = cache_pkg::FILL;
                end
            end

            cache_pkg::FILL: begin
                fill_read_o = 1'b1;
                if (fill_resp_i) begin
                    install      = 1'b1;
                    install_line = fill_rdata_i;
                    state_next   = cache_pkg::RESPOND;
                end
            end

            cache_pkg::RESPOND: begin
                mem_resp_o = 1'b1;
                state_next = cache_pkg::IDLE;
            end

            default: state_next = cache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state   <= cache_pkg::IDLE;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            state <= state_next;
            if (install) begin
                valid_q[req_set] <= 1'b1;
                dirty_q[req_set] <= install_dirty;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (install) begin
            tag_q[req_set]  <= req_tag;
            data_q[req_set] <= install_line;
        end
    end

endmodule : line_cache

`default_nettype wire

// File: hw/mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
    input  wire logic             clk,
    input  wire logic             rst,

    // Fill reads from the cache.
    input  wire logic             fill_read_i,
    input  wire cache_pkg::addr_t fill_addr_i,
    output logic                  fill_resp_o,
    output cache_pkg::line_t      fill_rdata_o,

    // Drain writes from the eviction buffer.
    input  wire logic             ewb_empty_i,
    input  wire cache_pkg::line_t ewb_data_i,
    input  wire cache_pkg::addr_t ewb_addr_i,
    output logic                  ewb_yumi_o,

    // Physical memory port.
    input  wire logic             pmem_resp_i,
    input  wire cache_pkg::line_t pmem_rdata_i,
    output logic                  pmem_read_o,
    output logic                  pmem_write_o,
    output cache_pkg::addr_t      pmem_addr_o,
    output cache_pkg::line_t      pmem_wdata_o
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_FILL,
        ARB_DRAIN
    } arb_state_t;

    arb_state_t state;
    arb_state_t state_next;

    // A new owner is chosen only from idle, and a pending fill beats a drain.
    always_comb begin
        state_next = state;
        case (state)
            ARB_IDLE: begin
                if (fill_read_i) begin
                    state_next = ARB_FILL;
                end else if (!ewb_empty_i) begin
                    state_next = ARB_DRAIN;
                end
            end
            ARB_FILL,
            ARB_DRAIN: begin
                if (pmem_resp_i) begin
                    state_next = ARB_IDLE;
                end
            end
            default: state_next = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= ARB_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Capture the owner's address and data when it is granted.
    always_ff @(posedge clk) begin
        if (state == ARB_IDLE) begin
            if (fill_read_i) begin
                pmem_addr_o <= fill_addr_i;
            end else if (!ewb_empty_i) begin
                pmem_addr_o  <= ewb_addr_i;
                pmem_wdata_o <= ewb_data_i;
            end
        end
    end

    assign pmem_read_o  = (state == ARB_FILL);
    assign pmem_write_o = (state == ARB_DRAIN);

    // The response goes back to the current owner only.
    assign fill_resp_o  = pmem_resp_i && (state == ARB_FILL);
    assign ewb_yumi_o   = pmem_resp_i && (state == ARB_DRAIN);
    assign fill_rdata_o = pmem_rdata_i;

endmodule : mem_arbiter

`default_nettype wire

// File: tb.f
hw/cache_pkg.sv
hw/ewb.sv
hw/line_cache.sv
hw/mem_arbiter.sv
hw/cache_subsystem.sv
test/tb_clock.sv
test/tb_mem_model.sv
test/tb_cache_subsystem.sv

// File: test/tb_cache_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cache_subsystem;

    localparam int TIMEOUT_CYCLES = 300;
    localparam int MAX_TESTS      = 64;
    localparam int MEM_SLOTS      = 256;

    logic             clk;
    logic             rst;
    logic             mem_read;
    logic             mem_write;
    cache_pkg::addr_t mem_addr;
    cache_pkg::line_t mem_wdata;
    logic             mem_resp;
    cache_pkg::line_t mem_rdata;
    logic             pmem_resp;
    cache_pkg::line_t pmem_rdata;
    logic             pmem_read;
    logic             pmem_write;
    cache_pkg::addr_t pmem_addr;
    cache_pkg::line_t pmem_wdata;

    // Stimulus table. A latency of zero means the latency is not checked.
    string            tbl_name  [MAX_TESTS];
    bit               tbl_write [MAX_TESTS];
    cache_pkg::addr_t tbl_addr  [MAX_TESTS];
    logic [31:0]      tbl_word  [MAX_TESTS];
    int               tbl_lat   [MAX_TESTS];
    int               tbl_count;

    // Reference copy of every line as the client last wrote it.
    cache_pkg::line_t     ref_line [MEM_SLOTS];
    logic [MEM_SLOTS-1:0] ref_written;

    tb_clock u_clock (.clk_o(clk));

    tb_mem_model u_mem (
        .clk          (clk),
        .rst          (rst),
        .pmem_read_i  (pmem_read),
        .pmem_write_i (pmem_write),
        .pmem_addr_i  (pmem_addr),
        .pmem_wdata_i (pmem_wdata),
        .pmem_resp_o  (pmem_resp),
        .pmem_rdata_o (pmem_rdata)
    );

    cache_subsystem u_dut (
        .clk          (clk),
        .rst          (rst),
        .mem_read_i   (mem_read),
        .mem_write_i  (mem_write),
        .mem_addr_i   (mem_addr),
        .mem_wdata_i  (mem_wdata),
        .mem_resp_o   (mem_resp),
        .mem_rdata_o  (mem_rdata),
        .pmem_resp_i  (pmem_resp),
        .pmem_rdata_i (pmem_rdata),
        .pmem_read_o  (pmem_read),
        .pmem_write_o (pmem_write),
        .pmem_addr_o  (pmem_addr),
        .pmem_wdata_o (pmem_wdata)
    );

    // Content that memory holds for a line before anyone writes it.
    function automatic cache_pkg::line_t initial_line(input cache_pkg::line_addr_t la);
        cache_pkg::line_t line;
        for (int w = 0; w < 8; w++) begin
            line[w*32 +: 32] = ({5'b0, la} * 32'h9E3779B9) ^ (w * 32'h0F0F1234) ^ 32'hC0DE0000;
        end
        return line;
    endfunction

    // Spread a 32-bit table word over all eight words of a line.
    function automatic cache_pkg::line_t expand_word(input logic [31:0] word);
        cache_pkg::line_t line;
        for (int w = 0; w < 8; w++) begin
            line[w*32 +: 32] = word ^ (w * 32'h01010101);
        end
        return line;
    endfunction

    function automatic cache_pkg::line_t expected_line(input cache_pkg::addr_t addr);
        cache_pkg::line_addr_t la;
        la = addr[cache_pkg::ADDR_BITS-1:cache_pkg::OFFSET_BITS];
        if (ref_written[la[7:0]]) begin
            return ref_line[la[7:0]];
        end else begin
            return initial_line(la);
        end
    endfunction

    task automatic add_entry(input string name, input bit is_write, input cache_pkg::addr_t addr,
                             input logic [31:0] word, input int lat);
        tbl_name[tbl_count]  = name;
        tbl_write[tbl_count] = is_write;
        tbl_addr[tbl_count]  = addr;
        tbl_word[tbl_count]  = word;
        tbl_lat[tbl_count]   = lat;
        tbl_count++;
    endtask

    // Set index is address bits 7 to 5, so 0x080 and 0x180 share set 4.
    task automatic build_table();
        int base;

        add_entry("cold_read",     1'b0, 32'h0000_0040, 32'h0, 0);
        add_entry("hit_read",      1'b0, 32'h0000_0040, 32'h0, 1);
        add_entry("write_line",    1'b1, 32'h0000_0064, 32'h1111_2222, 0);
        add_entry("read_written",  1'b0, 32'h0000_0060, 32'h0, 1);
        add_entry("conflict_wr_a", 1'b1, 32'h0000_0080, 32'hAAAA_0001, 0);
        add_entry("conflict_wr_b", 1'b1, 32'h0000_0180, 32'hBBBB_0002, 0);
        add_entry("conflict_rd_a", 1'b0, 32'h0000_0080, 32'h0, 0);
        // Eight dirty lines in set 6 overrun the four entry buffer.
        for (int k = 0; k < 8; k++) begin
            add_entry($sformatf("bp_write_%0d", k), 1'b1, 32'h0000_00C0 + k * 32'h100,
                      32'hD000_0000 + k, 0);
        end
        add_entry("bp_rewrite_2",  1'b1, 32'h0000_02C0, 32'hE000_0002, 0);
        base = tbl_count;
        for (int j = 0; j < base; j++) begin
            add_entry({"final_", tbl_name[j]}, 1'b0, tbl_addr[j], 32'h0, 0);
        end
    endtask

    initial begin
        int               idx;
        int               cycles;
        int               passed;
        int               failed;
        bit               timed_out;
        bit               ok;
        cache_pkg::line_t expected;
        cache_pkg::line_t actual;
        cache_pkg::line_addr_t la;

        rst         = 1'b1;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_addr    = '0;
        mem_wdata   = '0;
        ref_written = '0;
        tbl_count   = 0;
        passed      = 0;
        failed      = 0;
        timed_out   = 1'b0;

        build_table();

        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // With no request pending, neither port may be active after reset.
        @(negedge clk);
        if ({mem_resp, pmem_read, pmem_write} !== 3'b000) begin
            $display("ERROR reset_idle: expected %b actual %b", 3'b000,
                     {mem_resp, pmem_read, pmem_write});
            $display("reset_idle: failed");
            failed++;
        end else begin
            $display("reset_idle: ok");
            passed++;
        end
        @(posedge clk);

        idx = 0;
        while (idx < tbl_count && !timed_out) begin
            mem_read  <= !tbl_write[idx];
            mem_write <= tbl_write[idx];
            mem_addr  <= tbl_addr[idx];
            mem_wdata <= tbl_write[idx] ? expand_word(tbl_word[idx]) : '0;
            expected = expected_line(tbl_addr[idx]);
            if (tbl_write[idx]) begin
                la = tbl_addr[idx][cache_pkg::ADDR_BITS-1:cache_pkg::OFFSET_BITS];
                ref_line[la[7:0]]    = expand_word(tbl_word[idx]);
                ref_written[la[7:0]] = 1'b1;
            end

            // Outputs are sampled at the falling edge where they are stable.
            @(negedge clk);
            cycles = 0;
            while (!mem_resp && cycles < TIMEOUT_CYCLES) begin
                @(negedge clk);
                cycles++;
            end
            actual = mem_rdata;

            if (!mem_resp) begin
                $display("Timeout: %s got no response within %0d cycles",
                         tbl_name[idx], TIMEOUT_CYCLES);
                timed_out = 1'b1;
                failed++;
            end else begin
                ok = 1'b1;
                if (!tbl_write[idx] && actual !== expected) begin
                    $display("ERROR %s: expected %h actual %h", tbl_name[idx], expected, actual);
                    ok = 1'b0;
                end
                if (tbl_lat[idx] != 0 && cycles != tbl_lat[idx]) begin
                    $display("ERROR %s: expected latency %0d actual %0d",
                             tbl_name[idx], tbl_lat[idx], cycles);
                    ok = 1'b0;
                end
                if (ok) begin
                    passed++;
                    $display("%s: ok after %0d cycles", tbl_name[idx], cycles);
                end else begin
                    failed++;
                    $display("%s: failed", tbl_name[idx]);
                end
                @(posedge clk);
            end
            idx++;
        end

        mem_read  <= 1'b0;
        mem_write <= 1'b0;
        $display("%0d tests run, %0d passed, %0d failed", passed + failed, passed, failed);
        if (failed == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : tb_cache_subsystem

`default_nettype wire

// File: test/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clk_o
);

    // Half of the 4 ns clock period.
    localparam time HALF_PERIOD = 2;

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD clk_o = ~clk_o;
        end
    end

endmodule : tb_clock

`default_nettype wire

// File: test/tb_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_model (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             pmem_read_i,
    input  wire logic             pmem_write_i,
    input  wire cache_pkg::addr_t pmem_addr_i,
    input  wire cache_pkg::line_t pmem_wdata_i,
    output logic                  pmem_resp_o,
    output cache_pkg::line_t      pmem_rdata_o
);

    localparam int MEM_SLOTS = 256;

    // Storage covers the low 256 line addresses, which is all the test touches.
    cache_pkg::line_t store [MEM_SLOTS];
    logic [MEM_SLOTS-1:0] written;
    logic [7:0]           slot;
    logic [31:0]          lcg_state;
    logic                 busy;
    int                   wait_cnt;

    assign slot = pmem_addr_i[cache_pkg::OFFSET_BITS +: 8];

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Unwritten lines hold a pattern built from the whole line address.
    function automatic cache_pkg::line_t initial_line(input cache_pkg::line_addr_t la);
        cache_pkg::line_t line;
        for (int w = 0; w < 8; w++) begin
            line[w*32 +: 32] = ({5'b0, la} * 32'h9E3779B9) ^ (w * 32'h0F0F1234) ^ 32'hC0DE0000;
        end
        return line;
    endfunction

    always @(posedge clk, posedge rst) begin
        logic [31:0] nxt;

        if (rst) begin
            pmem_resp_o <= 1'b0;
            busy        <= 1'b0;
            wait_cnt    <= 0;
            written     <= '0;
            lcg_state   <= 32'd1798;
        end else begin
            pmem_resp_o <= 1'b0;
            if (busy) begin
                if (wait_cnt > 1) begin
                    wait_cnt <= wait_cnt - 1;
                end else begin
                    if (pmem_write_i) begin
                        store[slot]   <= pmem_wdata_i;
                        written[slot] <= 1'b1;
                    end else if (written[slot]) begin
                        pmem_rdata_o <= store[slot];
                    end else begin
                        pmem_rdata_o <= initial_line(pmem_addr_i[31:cache_pkg::OFFSET_BITS]);
                    end
                    busy        <= 1'b0;
                    pmem_resp_o <= 1'b1;
                end
            end else if ((pmem_read_i || pmem_write_i) && !pmem_resp_o) begin
                // Each access waits between 2 and 9 cycles.
                nxt       = lcg_next(lcg_state);
                lcg_state <= nxt;
                wait_cnt  <= 2 + int'(nxt[18:16]);
                busy      <= 1'b1;
            end
        end
    end

endmodule : tb_mem_model

`default_nettype wire
